/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -sv --top-module tb_img_edge -Mdir obj_dir -f files.f
	./obj_dir/Vtb_img_edge > sim.log 2>&1; cat sim.log; grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* files.f */
src/img_pkg.sv
src/img_window_3x3.sv
src/img_gaussian_3x3.sv
src/img_sobel.sv
src/img_grad_mask.sv
src/img_delay.sv
src/img_edge_top.sv
tests/tb_img_edge.sv

/* src/img_delay.sv */
`timescale 1ns/1ps
`default_nettype none

module img_delay #(
    parameter type T       = logic,
    parameter int  LATENCY = 1
) (
    input  wire     aclk,
    input  wire     arst_n_i,
    input  wire     valid_i,
    input  wire     line_first_i,
    input  wire     line_last_i,
    input  wire     pixel_first_i,
    input  wire     pixel_last_i,
    input  wire T   data_i,
    output logic    valid_o,
    output logic    line_first_o,
    output logic    line_last_o,
    output logic    pixel_first_o,
    output logic    pixel_last_o,
    output T        data_o
);

    T           data_q [LATENCY];
    logic [4:0] mark_q [LATENCY];

    always_ff @(posedge aclk) begin
        data_q[0] <= data_i;
        for (int i = 1; i < LATENCY; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    // markers: valid, line_first, line_last, pixel_first, pixel_last
    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < LATENCY; i++) begin
                mark_q[i] <= '0;
            end
        end else begin
            mark_q[0] <= {valid_i, line_first_i, line_last_i, pixel_first_i, pixel_last_i};
            for (int i = 1; i < LATENCY; i++) begin
                mark_q[i] <= mark_q[i-1];
            end
        end
    end

    assign {valid_o, line_first_o, line_last_o, pixel_first_o, pixel_last_o} = mark_q[LATENCY-1];
    assign data_o = data_q[LATENCY-1];

endmodule

`default_nettype wire

/* src/img_edge_top.sv */
`timescale 1ns/1ps
`default_nettype none

module img_edge_top import img_pkg::*; #(
    parameter int IMG_X_NUM = 640
) (
    input  wire            aclk,
    input  wire            arst_n_i,
    input  wire            valid_i,
    input  wire            line_first_i,
    input  wire            line_last_i,
    input  wire            pixel_first_i,
    input  wire            pixel_last_i,
    input  wire pix_t      data_i,
    input  wire weight_t   threshold_i,
    output logic           valid_o,
    output logic           line_first_o,
    output logic           line_last_o,
    output logic           pixel_first_o,
    output logic           pixel_last_o,
    output pix_t           gauss_o,
    output grad_t          grad_x_o,
    output grad_t          grad_y_o,
    output logic           mask_o
);

    logic  g_valid;
    logic  g_line_first;
    logic  g_line_last;
    logic  g_pixel_first;
    logic  g_pixel_last;
    pix_t  g_data;

    logic  s_valid;
    logic  s_line_first;
    logic  s_line_last;
    logic  s_pixel_first;
    logic  s_pixel_last;
    grad_t s_grad_x;
    grad_t s_grad_y;

    // ------------------------------
    // gaussian, 2 cycles
    // ------------------------------

    img_gaussian_3x3 #(
        .IMG_X_NUM     (IMG_X_NUM)
    ) gaussian_i (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .valid_i       (valid_i),
        .line_first_i  (line_first_i),
        .line_last_i   (line_last_i),
        .pixel_first_i (pixel_first_i),
        .pixel_last_i  (pixel_last_i),
        .data_i        (data_i),
        .valid_o       (g_valid),
        .line_first_o  (g_line_first),
        .line_last_o   (g_line_last),
        .pixel_first_o (g_pixel_first),
        .pixel_last_o  (g_pixel_last),
        .data_o        (g_data)
    );

    // ------------------------------
    // sobel, 2 cycles
    // ------------------------------

    img_sobel #(
        .IMG_X_NUM     (IMG_X_NUM)
    ) sobel_i (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .valid_i       (g_valid),
        .line_first_i  (g_line_first),
        .line_last_i   (g_line_last),
        .pixel_first_i (g_pixel_first),
        .pixel_last_i  (g_pixel_last),
        .data_i        (g_data),
        .valid_o       (s_valid),
        .line_first_o  (s_line_first),
        .line_last_o   (s_line_last),
        .pixel_first_o (s_pixel_first),
        .pixel_last_o  (s_pixel_last),
        .grad_x_o      (s_grad_x),
        .grad_y_o      (s_grad_y)
    );

    // ------------------------------
    // weight and mask, 2 cycles
    // ------------------------------

    img_grad_mask grad_mask_i (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .valid_i       (s_valid),
        .line_first_i  (s_line_first),
        .line_last_i   (s_line_last),
        .pixel_first_i (s_pixel_first),
        .pixel_last_i  (s_pixel_last),
        .grad_x_i      (s_grad_x),
        .grad_y_i      (s_grad_y),
        .threshold_i   (threshold_i),
        .valid_o       (valid_o),
        .line_first_o  (line_first_o),
        .line_last_o   (line_last_o),
        .pixel_first_o (pixel_first_o),
        .pixel_last_o  (pixel_last_o),
        .grad_x_o      (grad_x_o),
        .grad_y_o      (grad_y_o),
        .mask_o        (mask_o)
    );

    // gaussian result held back by sobel plus mask latency
    img_delay #(
        .T             (pix_t),
        .LATENCY       (4)
    ) gauss_delay_i (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .valid_i       (g_valid),
        .line_first_i  (g_line_first),
        .line_last_i   (g_line_last),
        .pixel_first_i (g_pixel_first),
        .pixel_last_i  (g_pixel_last),
        .data_i        (g_data),
        .valid_o       (),
        .line_first_o  (),
        .line_last_o   (),
        .pixel_first_o (),
        .pixel_last_o  (),
        .data_o        (gauss_o)
    );

endmodule

`default_nettype wire

/* src/img_gaussian_3x3.sv */
`timescale 1ns/1ps
`default_nettype none

module img_gaussian_3x3 import img_pkg::*; #(
    parameter int IMG_X_NUM = 640
) (
    input  wire          aclk,
    input  wire          arst_n_i,
    input  wire          valid_i,
    input  wire          line_first_i,
    input  wire          line_last_i,
    input  wire          pixel_first_i,
    input  wire          pixel_last_i,
    input  wire pix_t    data_i,
    output logic         valid_o,
    output logic         line_first_o,
    output logic         line_last_o,
    output logic         pixel_first_o,
    output logic         pixel_last_o,
    output pix_t         data_o
);

    logic        win_valid;
    win3x3_t     win;
    logic [13:0] acc;
    logic [3:0]  mark_d1;
    logic [3:0]  mark_d2;
    logic        valid_q;
    pix_t        data_q;

    img_window_3x3 #(
        .IMG_X_NUM     (IMG_X_NUM)
    ) window_i (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .valid_i       (valid_i),
        .line_first_i  (line_first_i),
        .pixel_first_i (pixel_first_i),
        .data_i        (data_i),
        .valid_o       (win_valid),
        .win_o         (win)
    );

    // 1-2-1 x 1-2-1 kernel, total weight 16, plus half for rounding
    assign acc = win[0][0] + (win[0][1] << 1) + win[0][2]
               + (win[1][0] << 1) + (win[1][1] << 2) + (win[1][2] << 1)
               + win[2][0] + (win[2][1] << 1) + win[2][2]
               + 14'd8;

    always_ff @(posedge aclk) begin
        if (win_valid) begin
            data_q <= pix_t'(acc >> 4);
        end
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mark_d1 <= '0;
            mark_d2 <= '0;
            valid_q <= 1'b0;
        end else begin
            mark_d1 <= {line_first_i, line_last_i, pixel_first_i, pixel_last_i};
            mark_d2 <= mark_d1;
            valid_q <= win_valid;
        end
    end

    assign {line_first_o, line_last_o, pixel_first_o, pixel_last_o} = mark_d2;
    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

`default_nettype wire

/* src/img_grad_mask.sv */
`timescale 1ns/1ps
`default_nettype none

module img_grad_mask import img_pkg::*; (
    input  wire            aclk,
    input  wire            arst_n_i,
    input  wire            valid_i,
    input  wire            line_first_i,
    input  wire            line_last_i,
    input  wire            pixel_first_i,
    input  wire            pixel_last_i,
    input  wire grad_t     grad_x_i,
    input  wire grad_t     grad_y_i,
    input  wire weight_t   threshold_i,
    output logic           valid_o,
    output logic           line_first_o,
    output logic           line_last_o,
    output logic           pixel_first_o,
    output logic           pixel_last_o,
    output grad_t          grad_x_o,
    output grad_t          grad_y_o,
    output logic           mask_o
);

    grad2_t     sq_x;
    grad2_t     sq_y;
    grad2_t     grad2_q;
    weight_t    weight;
    grad_t      gx_d1;
    grad_t      gy_d1;
    grad_t      gx_d2;
    grad_t      gy_d2;
    logic       mask_q;
    logic [4:0] mark_d1;
    logic [4:0] mark_d2;

    assign sq_x = grad_x_i * grad_x_i;
    assign sq_y = grad_y_i * grad_y_i;

    // sum is never negative, top bits drop out after the shift
    assign weight = weight_t'(grad2_q >>> WEIGHT_SHIFT);

    // ------------------------------
    // stage 1 sum, stage 2 compare
    // ------------------------------

    always_ff @(posedge aclk) begin
        grad2_q <= sq_x + sq_y;
        gx_d1   <= grad_x_i;
        gy_d1   <= grad_y_i;
        gx_d2   <= gx_d1;
        gy_d2   <= gy_d1;
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mark_d1 <= '0;
            mark_d2 <= '0;
            mask_q  <= 1'b0;
        end else begin
            mark_d1 <= {valid_i, line_first_i, line_last_i, pixel_first_i, pixel_last_i};
            mark_d2 <= mark_d1;
            mask_q  <= (weight > threshold_i);
        end
    end

    assign {valid_o, line_first_o, line_last_o, pixel_first_o, pixel_last_o} = mark_d2;
    assign grad_x_o = gx_d2;
    assign grad_y_o = gy_d2;
    assign mask_o   = mask_q;

endmodule

`default_nettype wire

/* src/img_pkg.sv */
`default_nettype none

package img_pkg;

    // gray pixel straight from the sensor path
    typedef logic [9:0] pix_t;

    // sobel gradient, one sign bit over the pixel range
    typedef logic signed [10:0] grad_t;

    // grad_x^2 + grad_y^2
    typedef logic signed [21:0] grad2_t;

    // sum of squares after scaling
    typedef logic [13:0] weight_t;

    localparam int WEIGHT_SHIFT = 8;

    // [row][col], index 0 is the oldest row or column
    typedef pix_t win3x3_t [3][3];

endpackage

`default_nettype wire

/* src/img_sobel.sv */
`timescale 1ns/1ps
`default_nettype none

module img_sobel import img_pkg::*; #(
    parameter int IMG_X_NUM = 640
) (
    input  wire          aclk,
    input  wire          arst_n_i,
    input  wire          valid_i,
    input  wire          line_first_i,
    input  wire          line_last_i,
    input  wire          pixel_first_i,
    input  wire          pixel_last_i,
    input  wire pix_t    data_i,
    output logic         valid_o,
    output logic         line_first_o,
    output logic         line_last_o,
    output logic         pixel_first_o,
    output logic         pixel_last_o,
    output grad_t        grad_x_o,
    output grad_t        grad_y_o
);

    logic               win_valid;
    win3x3_t            win;
    logic [11:0]        col_new;
    logic [11:0]        col_old;
    logic [11:0]        row_new;
    logic [11:0]        row_old;
    logic signed [12:0] gx_full;
    logic signed [12:0] gy_full;
    logic [3:0]         mark_d1;
    logic [3:0]         mark_d2;
    logic               valid_q;
    grad_t              grad_x_q;
    grad_t              grad_y_q;

    img_window_3x3 #(
        .IMG_X_NUM     (IMG_X_NUM)
    ) window_i (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .valid_i       (valid_i),
        .line_first_i  (line_first_i),
        .pixel_first_i (pixel_first_i),
        .data_i        (data_i),
        .valid_o       (win_valid),
        .win_o         (win)
    );

    // weighted edge columns and rows
    assign col_new = win[0][2] + (win[1][2] << 1) + win[2][2];
    assign col_old = win[0][0] + (win[1][0] << 1) + win[2][0];
    assign row_new = win[2][0] + (win[2][1] << 1) + win[2][2];
    assign row_old = win[0][0] + (win[0][1] << 1) + win[0][2];

    assign gx_full = $signed({1'b0, col_new}) - $signed({1'b0, col_old});
    assign gy_full = $signed({1'b0, row_new}) - $signed({1'b0, row_old});

    // divide by 4 keeps the range within grad_t
    always_ff @(posedge aclk) begin
        if (win_valid) begin
            grad_x_q <= grad_t'(gx_full >>> 2);
            grad_y_q <= grad_t'(gy_full >>> 2);
        end
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mark_d1 <= '0;
            mark_d2 <= '0;
            valid_q <= 1'b0;
        end else begin
            mark_d1 <= {line_first_i, line_last_i, pixel_first_i, pixel_last_i};
            mark_d2 <= mark_d1;
            valid_q <= win_valid;
        end
    end

    assign {line_first_o, line_last_o, pixel_first_o, pixel_last_o} = mark_d2;
    assign valid_o  = valid_q;
    assign grad_x_o = grad_x_q;
    assign grad_y_o = grad_y_q;

endmodule

`default_nettype wire

/* src/img_window_3x3.sv */
`timescale 1ns/1ps
`default_nettype none

module img_window_3x3 import img_pkg::*; #(
    parameter int IMG_X_NUM = 640
) (
    input  wire          aclk,
    input  wire          arst_n_i,
    input  wire          valid_i,
    input  wire          line_first_i,
    input  wire          pixel_first_i,
    input  wire pix_t    data_i,
    output logic         valid_o,
    output win3x3_t      win_o
);

    localparam int X_W = (IMG_X_NUM > 1) ? $clog2(IMG_X_NUM) : 1;

    logic [X_W-1:0] x_cnt;
    logic [X_W-1:0] x_cur;
    logic [1:0]     row_q;
    logic [1:0]     row_cur;
    logic [1:0]     col_q;
    logic [1:0]     col_cur;
    logic           valid_q;

    pix_t           lb1_mem [IMG_X_NUM];
    pix_t           lb2_mem [IMG_X_NUM];
    pix_t           up1;
    pix_t           up2;
    pix_t           col_new [3];
    win3x3_t        win_q;

    // ------------------------------
    // position tracking
    // ------------------------------

    // depth saturates at 2, enough history for a full window
    always_comb begin
        x_cur = pixel_first_i ? '0 : x_cnt;

        if (line_first_i) begin
            row_cur = 2'd0;
        end else if (pixel_first_i) begin
            row_cur = (row_q == 2'd2) ? 2'd2 : row_q + 2'd1;
        end else begin
            row_cur = row_q;
        end

        if (pixel_first_i) begin
            col_cur = 2'd0;
        end else begin
            col_cur = (col_q == 2'd2) ? 2'd2 : col_q + 2'd1;
        end
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            x_cnt   <= '0;
            row_q   <= 2'd0;
            col_q   <= 2'd0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
            if (valid_i) begin
                x_cnt <= x_cur + 1'b1;
                row_q <= row_cur;
                col_q <= col_cur;
            end
        end
    end

    // ------------------------------
    // line buffers and window
    // ------------------------------

    assign up1 = lb1_mem[x_cur];
    assign up2 = lb2_mem[x_cur];

    // missing upper rows take the oldest row present
    always_comb begin
        col_new[2] = data_i;
        case (row_cur)
            2'd0: begin
                col_new[0] = data_i;
                col_new[1] = data_i;
            end
            2'd1: begin
                col_new[0] = up1;
                col_new[1] = up1;
            end
            default: begin
                col_new[0] = up2;
                col_new[1] = up1;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (valid_i) begin
            lb1_mem[x_cur] <= data_i;
            lb2_mem[x_cur] <= up1;
            for (int r = 0; r < 3; r++) begin
                case (col_cur)
                    2'd0: begin
                        win_q[r][0] <= col_new[r];
                        win_q[r][1] <= col_new[r];
                    end
                    2'd1: begin
                        win_q[r][0] <= win_q[r][2];
                        win_q[r][1] <= win_q[r][2];
                    end
                    default: begin
                        win_q[r][0] <= win_q[r][1];
                        win_q[r][1] <= win_q[r][2];
                    end
                endcase
                win_q[r][2] <= col_new[r];
            end
        end
    end

    assign valid_o = valid_q;
    assign win_o   = win_q;

endmodule

`default_nettype wire

/* tests/img_edge_testdata.txt */
# threshold on the first data line, then one pixel per line with columns
# pixel_first pixel_last line_first line_last pixel gauss grad_x grad_y mask
89
1 0 1 0 20 20 0 0 0
0 0 1 0 21 20 0 0 0
0 0 1 0 25 22 2 0 0
0 0 1 0 300 93 73 0 0
0 0 1 0 310 234 212 0 1
0 0 1 0 305 306 213 0 1
0 0 1 0 40 240 6 0 0
0 1 1 0 43 107 -199 0 1
1 0 0 0 24 21 0 1 0
0 0 0 0 25 21 0 1 0
0 0 0 0 29 23 2 1 0
0 0 0 0 304 94 73 1 0
0 0 0 0 314 235 212 1 1
0 0 0 0 309 307 213 1 1
0 0 0 0 44 241 6 1 0
0 1 0 0 47 108 -199 1 1
1 0 0 0 220 72 0 52 0
0 0 0 0 221 72 0 52 0
0 0 0 0 225 74 2 52 0
0 0 0 0 500 145 73 52 0
0 0 0 0 510 286 212 52 1
0 0 0 0 505 358 213 52 1
0 0 0 0 240 292 6 52 0
0 1 0 0 243 159 -199 52 1
1 0 0 0 224 172 0 151 0
0 0 0 0 225 172 0 151 0
0 0 0 0 229 174 2 151 0
0 0 0 0 504 245 73 151 1
0 0 0 0 514 386 212 151 1
0 0 0 0 509 458 213 151 1
0 0 0 0 244 392 6 151 0
0 1 0 0 247 259 -199 151 1
1 0 0 0 100 192 0 120 0
0 0 0 0 101 192 0 120 0
0 0 0 0 105 194 2 120 0
0 0 0 0 380 265 73 120 0
0 0 0 0 390 406 212 120 1
0 0 0 0 385 478 213 120 1
0 0 0 0 120 412 6 120 0
0 1 0 0 123 279 -199 120 1
1 0 0 1 100 131 0 -41 0
0 0 0 1 101 131 0 -41 0
0 0 0 1 105 133 2 -41 0
0 0 0 1 380 204 73 -41 0
0 0 0 1 390 345 212 -41 1
0 0 0 1 385 417 213 -41 1
0 0 0 1 120 351 6 -41 0
0 1 0 1 123 218 -199 -41 1

/* tests/tb_img_edge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_img_edge import img_pkg::*; ();

    localparam int    IMG_X_NUM = 8;
    localparam string DATA_FILE = "tests/img_edge_testdata.txt";

    typedef struct packed {
        logic  pixel_first;
        logic  pixel_last;
        logic  line_first;
        logic  line_last;
        pix_t  pixel;
        pix_t  gauss;
        grad_t grad_x;
        grad_t grad_y;
        logic  mask;
    } pixel_rec_t;

    logic       aclk;
    logic       arst_n_i;
    logic       valid_i;
    logic       line_first_i;
    logic       line_last_i;
    logic       pixel_first_i;
    logic       pixel_last_i;
    pix_t       data_i;
    weight_t    threshold_i;
    logic       valid_o;
    logic       line_first_o;
    logic       line_last_o;
    logic       pixel_first_o;
    logic       pixel_last_o;
    pix_t       gauss_o;
    grad_t      grad_x_o;
    grad_t      grad_y_o;
    logic       mask_o;

    pixel_rec_t stim_q [$];
    pixel_rec_t exp_q [$];
    pixel_rec_t got_rec;
    weight_t    file_threshold;
    int         n_pix;
    int         rx_count;
    int         cycle_count;
    int         cycle_limit;
    logic [7:0] lfsr_state;

    img_edge_top #(
        .IMG_X_NUM     (IMG_X_NUM)
    ) dut_i (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .valid_i       (valid_i),
        .line_first_i  (line_first_i),
        .line_last_i   (line_last_i),
        .pixel_first_i (pixel_first_i),
        .pixel_last_i  (pixel_last_i),
        .data_i        (data_i),
        .threshold_i   (threshold_i),
        .valid_o       (valid_o),
        .line_first_o  (line_first_o),
        .line_last_o   (line_last_o),
        .pixel_first_o (pixel_first_o),
        .pixel_last_o  (pixel_last_o),
        .gauss_o       (gauss_o),
        .grad_x_o      (grad_x_o),
        .grad_y_o      (grad_y_o),
        .mask_o        (mask_o)
    );

    // ------------------------------
    // helpers
    // ------------------------------

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_pix(input string name, input pix_t exp, input pix_t act);
        if (exp !== act) begin
            $display("Fail at %0t ns: %s expected %0d actual %0d", $time, name, exp, act);
            abort_run("pixel value mismatch");
        end
    endtask

    task automatic check_grad(input string name, input grad_t exp, input grad_t act);
        if (exp !== act) begin
            $display("Fail at %0t ns: %s expected %0d actual %0d", $time, name, exp, act);
            abort_run("gradient value mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Fail at %0t ns: %s expected %0b actual %0b", $time, name, exp, act);
            abort_run("flag value mismatch");
        end
    endtask

    // galois form with taps x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        logic [7:0] nxt;
        nxt = state >> 1;
        if (state[0]) begin
            nxt = nxt ^ 8'hB8;
        end
        return nxt;
    endfunction

    // lines starting with # are skipped and the first data line is the threshold
    task automatic read_testdata();
        int         fd;
        int         code;
        int         fields;
        int         pf_v, pl_v, lf_v, ll_v;
        int         pix_v, gs_v, gx_v, gy_v, mk_v;
        int         thr_v;
        bit         have_thr;
        string      line;
        pixel_rec_t rec;
        have_thr = 1'b0;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            abort_run("could not open the test data file");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                if (!have_thr) begin
                    fields = $sscanf(line, "%d", thr_v);
                    if (fields != 1) begin
                        abort_run("threshold line in the test data is malformed");
                    end
                    file_threshold = weight_t'(thr_v);
                    have_thr = 1'b1;
                end else begin
                    fields = $sscanf(line, "%d %d %d %d %d %d %d %d %d", pf_v, pl_v,
                                     lf_v, ll_v, pix_v, gs_v, gx_v, gy_v, mk_v);
                    if (fields != 9) begin
                        abort_run("pixel line in the test data is malformed");
                    end
                    rec.pixel_first = pf_v[0];
                    rec.pixel_last  = pl_v[0];
                    rec.line_first  = lf_v[0];
                    rec.line_last   = ll_v[0];
                    rec.pixel       = pix_t'(pix_v);
                    rec.gauss       = pix_t'(gs_v);
                    rec.grad_x      = grad_t'(gx_v);
                    rec.grad_y      = grad_t'(gy_v);
                    rec.mask        = mk_v[0];
                    stim_q.push_back(rec);
                end
            end
        end
        $fclose(fd);
        n_pix = stim_q.size();
        if (n_pix == 0) begin
            abort_run("test data holds no pixels");
        end
        // reset plus one gap per pixel at worst plus margin
        cycle_limit = 8 + 2 * n_pix + 20;
    endtask

    task automatic drive_idle();
        valid_i       = 1'b0;
        line_first_i  = 1'b0;
        line_last_i   = 1'b0;
        pixel_first_i = 1'b0;
        pixel_last_i  = 1'b0;
    endtask

    task automatic drive_pixel(input pixel_rec_t rec);
        valid_i       = 1'b1;
        line_first_i  = rec.line_first;
        line_last_i   = rec.line_last;
        pixel_first_i = rec.pixel_first;
        pixel_last_i  = rec.pixel_last;
        data_i        = rec.pixel;
        exp_q.push_back(rec);
    endtask

    // ------------------------------
    // clock, timeout, monitor
    // ------------------------------

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles, outputs stopped early", cycle_count));
        end
    end

    // outputs only move on the rising edge
    always @(negedge aclk) begin
        if (valid_o) begin
            if (exp_q.size() == 0) begin
                abort_run("valid_o came up with no pixel outstanding");
            end else begin
                got_rec = exp_q.pop_front();
                check_pix("gauss_o", got_rec.gauss, gauss_o);
                check_grad("grad_x_o", got_rec.grad_x, grad_x_o);
                check_grad("grad_y_o", got_rec.grad_y, grad_y_o);
                check_bit("mask_o", got_rec.mask, mask_o);
                check_bit("line_first_o", got_rec.line_first, line_first_o);
                check_bit("line_last_o", got_rec.line_last, line_last_o);
                check_bit("pixel_first_o", got_rec.pixel_first, pixel_first_o);
                check_bit("pixel_last_o", got_rec.pixel_last, pixel_last_o);
                rx_count = rx_count + 1;
            end
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------

    initial begin
        arst_n_i    = 1'b0;
        data_i      = '0;
        threshold_i = '0;
        drive_idle();
        rx_count    = 0;
        cycle_count = 0;
        cycle_limit = 0;
        lfsr_state  = 8'd60;

        read_testdata();
        threshold_i = file_threshold;

        repeat (8) @(posedge aclk);
        #1 arst_n_i = 1'b1;
        repeat (2) @(posedge aclk);

        for (int i = 0; i < n_pix; i++) begin
            @(posedge aclk);
            #1 drive_pixel(stim_q[i]);
            lfsr_state = lfsr_next(lfsr_state);
            if (!lfsr_state[0]) begin
                @(posedge aclk);
                #1 drive_idle();
            end
        end
        @(posedge aclk);
        #1 drive_idle();

        wait (rx_count == n_pix);
        // no extra valid_o after the frame
        repeat (4) @(posedge aclk);

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire
